//--- include/rv_defs.svh
// Core-wide constants for the RV32I pipeline
// Data width, register address width, reset PC, NOP word, opcodes

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN        32
`define RV_REG_AW      5

// First fetch address after reset
`define RV_RESET_ADDR  32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP         32'h0000_0013

// Major opcodes, instr[6:0]
`define RV_OP_ALU      7'b0110011
`define RV_OP_ALUI     7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_JAL      7'b1101111

`endif

//--- verilog/rv_pkg.sv
// Shared types of the RV32I pipeline
// Instruction views, ALU and forwarding encodings, stage registers

`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [19:0]           imm20;   // LUI immediate or scrambled JAL offset
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_e               alu_op;
        logic                  use_imm;   // Operand B is the immediate
        logic                  is_lui;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  branch_ne; // BNE when set, else BEQ
        logic                  is_jal;
        logic                  reg_we;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  is_load;
        logic                  is_store;
        logic                  reg_we;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_we;
    } mem_wb_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                we;
        logic                re;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- verilog/rv_fetch.sv
// Fetch stage
// Program counter and the IF/ID register

`default_nettype none

`include "rv_defs.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                stall_i,
    input  wire logic                flush_i,
    input  wire logic                redirect_i,
    input  wire logic [`RV_XLEN-1:0] target_i,
    input  wire logic [`RV_XLEN-1:0] instr_data_i,
    output logic [`RV_XLEN-1:0]      instr_addr_o,
    output logic [`RV_XLEN-1:0]      if_pc_o,
    output instr_u                   if_instr_o
);

    logic [`RV_XLEN-1:0] pc;

    assign instr_addr_o = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_ADDR;
        end else if (redirect_i) begin    // Taken branch or JAL beats a stall
            pc <= target_i;
        end else if (!stall_i) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr_o <= `RV_NOP;
            if_pc_o    <= `RV_RESET_ADDR;
        end else if (flush_i) begin
            if_instr_o <= `RV_NOP;        // Squash the wrong-path fetch
        end else if (!stall_i) begin
            if_instr_o <= instr_data_i;
            if_pc_o    <= pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_decode.sv
// Decode stage
// Field split, immediate generation, control decode, ID/EX register

`default_nettype none

`include "rv_defs.svh"

module rv_decode
    import rv_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                stall_i,
    input  wire logic                flush_i,
    input  wire logic [`RV_XLEN-1:0] if_pc_i,
    input  wire instr_u              if_instr_i,
    input  wire logic [`RV_XLEN-1:0] rs1_data_i,
    input  wire logic [`RV_XLEN-1:0] rs2_data_i,
    output logic [`RV_REG_AW-1:0]    rs1_addr_o,
    output logic [`RV_REG_AW-1:0]    rs2_addr_o,
    output id_ex_t                   id_ex_o
);

    // funct7[5] picks SUB/SRA, callers mask it where it is an immediate bit
    function automatic alu_op_e alu_decode(input logic alt, input logic [2:0] funct3);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    r_fmt_t              r;
    u_fmt_t              u;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    id_ex_t              id_ex_d;

    assign r = if_instr_i.r_fmt;
    assign u = if_instr_i.u_fmt;

    assign rs1_addr_o = r.rs1;
    assign rs2_addr_o = r.rs2;

    assign imm_i = {{20{r.funct7[6]}}, r.funct7, r.rs2};
    assign imm_s = {{20{r.funct7[6]}}, r.funct7, r.rd};
    assign imm_b = {{20{r.funct7[6]}}, r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};
    assign imm_u = {u.imm20, 12'b0};
    assign imm_j = {{12{u.imm20[19]}}, u.imm20[7:0], u.imm20[8], u.imm20[18:9], 1'b0};

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.pc       = if_pc_i;
        id_ex_d.rs1_data = rs1_data_i;
        id_ex_d.rs2_data = rs2_data_i;
        id_ex_d.rs1      = r.rs1;
        id_ex_d.rs2      = r.rs2;
        id_ex_d.rd       = r.rd;
        id_ex_d.valid    = 1'b1;
        case (r.opcode)
            `RV_OP_ALU: begin
                id_ex_d.alu_op = alu_decode(r.funct7[5], r.funct3);
                id_ex_d.reg_we = 1'b1;
            end
            `RV_OP_ALUI: begin
                // Only SRAI carries an alternate bit in its immediate
                id_ex_d.alu_op  = alu_decode(r.funct7[5] && r.funct3 == 3'b101, r.funct3);
                id_ex_d.imm     = imm_i;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            `RV_OP_LUI: begin
                id_ex_d.imm     = imm_u;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.is_lui  = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            `RV_OP_LOAD: begin
                id_ex_d.imm     = imm_i;     // Address is rs1 + imm
                id_ex_d.use_imm = 1'b1;
                id_ex_d.is_load = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            `RV_OP_STORE: begin
                id_ex_d.imm      = imm_s;
                id_ex_d.use_imm  = 1'b1;
                id_ex_d.is_store = 1'b1;
            end
            `RV_OP_BRANCH: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
                id_ex_d.branch_ne = r.funct3[0];
            end
            `RV_OP_JAL: begin
                id_ex_d.imm    = imm_j;
                id_ex_d.is_jal = 1'b1;
                id_ex_d.reg_we = 1'b1;
            end
            default: id_ex_d.valid = 1'b0; // Unsupported opcode retires as a no-op
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o <= '0;
        end else if (stall_i || flush_i) begin
            id_ex_o <= '0;               // Bubble
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
// Integer register file
// Two read ports, one write port, reads see a same-cycle write

`default_nettype none

`include "rv_defs.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`RV_REG_AW-1:0] rs1_addr_i,
    input  wire logic [`RV_REG_AW-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]        rs1_data_o,
    output logic [`RV_XLEN-1:0]        rs2_data_o,
    input  wire mem_wb_t               wb_i
);

    logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage
    logic                wr_en;

    assign wr_en = wb_i.reg_we && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    always_comb begin
        if (rs1_addr_i == '0)                          rs1_data_o = '0;
        else if (wr_en && wb_i.rd == rs1_addr_i)       rs1_data_o = wb_i.result; // Write-through
        else                                           rs1_data_o = regs[rs1_addr_i];
        if (rs2_addr_i == '0)                          rs2_data_o = '0;
        else if (wr_en && wb_i.rd == rs2_addr_i)       rs2_data_o = wb_i.result;
        else                                           rs2_data_o = regs[rs2_addr_i];
    end

endmodule

`default_nettype wire

//--- verilog/rv_hazard_ctrl.sv
// Pipeline hazard control
// Load-use stall, redirect flush and operand forwarding selects

`default_nettype none

`include "rv_defs.svh"

module rv_hazard_ctrl
    import rv_pkg::*;
(
    input  wire logic [`RV_REG_AW-1:0] if_rs1_i,
    input  wire logic [`RV_REG_AW-1:0] if_rs2_i,
    input  wire id_ex_t                id_ex_i,
    input  wire ex_mem_t               ex_mem_i,
    input  wire mem_wb_t               mem_wb_i,
    input  wire logic                  redirect_i,
    output logic                       stall_o,
    output logic                       flush_o,
    output fwd_sel_e                   fwd_a_o,
    output fwd_sel_e                   fwd_b_o
);

    // Load result only exists after MEM, so EX/MEM never supplies it
    function automatic fwd_sel_e fwd_pick(input logic [`RV_REG_AW-1:0] src,
                                          input ex_mem_t exm,
                                          input mem_wb_t mwb);
        if (src == '0)
            return FWD_NONE;
        if (exm.reg_we && !exm.is_load && exm.rd == src)
            return FWD_EXMEM;
        if (mwb.reg_we && mwb.rd == src)
            return FWD_MEMWB;
        return FWD_NONE;
    endfunction

    logic load_use;

    assign load_use = id_ex_i.is_load && (id_ex_i.rd != '0) &&
                      (if_rs1_i == id_ex_i.rd || if_rs2_i == id_ex_i.rd);

    assign stall_o = load_use;
    assign flush_o = redirect_i;    // Kill IF/ID and ID/EX behind a taken branch or JAL

    assign fwd_a_o = fwd_pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = fwd_pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
// Execute stage
// Forwarding muxes, ALU, branch resolution and the EX/MEM register

`default_nettype none

`include "rv_defs.svh"

module rv_execute
    import rv_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire id_ex_t              id_ex_i,
    input  wire fwd_sel_e            fwd_a_i,
    input  wire fwd_sel_e            fwd_b_i,
    input  wire logic [`RV_XLEN-1:0] ex_mem_fwd_i,
    input  wire mem_wb_t             mem_wb_i,
    output logic                     redirect_o,
    output logic [`RV_XLEN-1:0]      target_o,
    output ex_mem_t                  ex_mem_o
);

    function automatic logic [`RV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                    input logic [`RV_XLEN-1:0] reg_val,
                                                    input logic [`RV_XLEN-1:0] exm_val,
                                                    input logic [`RV_XLEN-1:0] mwb_val);
        case (sel)
            FWD_EXMEM: return exm_val;
            FWD_MEMWB: return mwb_val;
            default:   return reg_val;
        endcase
    endfunction

    logic [`RV_XLEN-1:0] rs1_val, rs2_val;
    logic [`RV_XLEN-1:0] op_a, op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [4:0]          shamt;
    logic                taken;

    assign rs1_val = fwd_mux(fwd_a_i, id_ex_i.rs1_data, ex_mem_fwd_i, mem_wb_i.result);
    assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, ex_mem_fwd_i, mem_wb_i.result);

    assign op_a  = id_ex_i.is_lui ? '0 : rs1_val;   // LUI is 0 + imm
    assign op_b  = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // BEQ/BNE only need equality
    assign taken      = id_ex_i.branch_ne ^ (rs1_val == rs2_val);
    assign target_o   = id_ex_i.pc + id_ex_i.imm;
    assign redirect_o = id_ex_i.valid && (id_ex_i.is_jal || (id_ex_i.is_branch && taken));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.result     <= id_ex_i.is_jal ? id_ex_i.pc + `RV_XLEN'd4 : alu_res; // Link
            ex_mem_o.store_data <= rs2_val;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.is_load    <= id_ex_i.is_load;
            ex_mem_o.is_store   <= id_ex_i.is_store;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_memwb.sv
// Memory stage
// Data memory request, writeback select and the MEM/WB register

`default_nettype none

`include "rv_defs.svh"

module rv_memwb
    import rv_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ex_mem_t             ex_mem_i,
    input  wire logic [`RV_XLEN-1:0] dmem_rdata_i,
    output dmem_req_t                dmem_o,
    output mem_wb_t                  mem_wb_o
);

    logic [`RV_XLEN-1:0] wb_data;

    assign dmem_o.addr  = ex_mem_i.result;
    assign dmem_o.wdata = ex_mem_i.store_data;
    assign dmem_o.we    = ex_mem_i.is_store;
    assign dmem_o.re    = ex_mem_i.is_load;

    // Read data returns in the same cycle
    assign wb_data = ex_mem_i.is_load ? dmem_rdata_i : ex_mem_i.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.result <= wb_data;
            mem_wb_o.rd     <= ex_mem_i.rd;
            mem_wb_o.reg_we <= ex_mem_i.reg_we;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// RV32I five-stage pipeline top
// Connects fetch, decode, register file, hazard control, execute and memwb

`default_nettype none

`include "rv_defs.svh"

module rv_core
    import rv_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    output logic [`RV_XLEN-1:0]      instr_addr_o,
    input  wire logic [`RV_XLEN-1:0] instr_data_i,
    output dmem_req_t                dmem_o,
    input  wire logic [`RV_XLEN-1:0] dmem_rdata_i
);

    logic                  stall;
    logic                  flush;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
    logic [`RV_XLEN-1:0]   if_pc;
    instr_u                if_instr;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;

    rv_fetch i_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall),
        .flush_i      (flush),
        .redirect_i   (redirect),
        .target_i     (target),
        .instr_data_i (instr_data_i),
        .instr_addr_o (instr_addr_o),
        .if_pc_o      (if_pc),
        .if_instr_o   (if_instr)
    );

    rv_decode i_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall),
        .flush_i    (flush),
        .if_pc_i    (if_pc),
        .if_instr_i (if_instr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .id_ex_o    (id_ex)
    );

    rv_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (mem_wb)
    );

    rv_hazard_ctrl i_hazard_ctrl (
        .if_rs1_i   (rs1_addr),
        .if_rs2_i   (rs2_addr),
        .id_ex_i    (id_ex),
        .ex_mem_i   (ex_mem),
        .mem_wb_i   (mem_wb),
        .redirect_i (redirect),
        .stall_o    (stall),
        .flush_o    (flush),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

    rv_execute i_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_ex_i      (id_ex),
        .fwd_a_i      (fwd_a),
        .fwd_b_i      (fwd_b),
        .ex_mem_fwd_i (ex_mem.result),
        .mem_wb_i     (mem_wb),
        .redirect_o   (redirect),
        .target_o     (target),
        .ex_mem_o     (ex_mem)
    );

    rv_memwb i_memwb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_o       (dmem_o),
        .mem_wb_o     (mem_wb)
    );

endmodule

`default_nettype wire

//--- sim/tb_rv_mem.sv
// Memory model for the core testbench
// Instruction ROM and 64-word data RAM, both read asynchronously
// RAM starts with seeded random words, each store is reported one cycle later

`default_nettype none

`include "rv_defs.svh"

module tb_rv_mem
    import rv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic [31:0] instr_addr_i,
    output logic [31:0]      instr_data_o,
    input  wire dmem_req_t   dmem_i,
    output logic [31:0]      dmem_rdata_o,
    output logic             st_valid_o,
    output logic [31:0]      st_addr_o,
    output logic [31:0]      st_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] rom [256];
    logic [31:0] ram [64];

    initial begin
        void'($urandom(11));
        for (int i = 0; i < 64; i++) begin
            ram[i] = $urandom;
        end
        for (int i = 0; i < 256; i++) begin
            rom[i] = `RV_NOP;      // Unused slots decode as no-ops
        end
    end

    assign instr_data_o = rom[instr_addr_i[9:2]];
    assign dmem_rdata_o = ram[dmem_i.addr[7:2]];   // Word index, no wait states

    always @(posedge clk) begin
        st_valid_o <= dmem_i.we;
        st_addr_o  <= dmem_i.addr;
        st_data_o  <= dmem_i.wdata;
        if (dmem_i.we) begin
            ram[dmem_i.addr[7:2]] <= dmem_i.wdata;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_rv_core.sv
// Testbench for the RV32I pipeline core
// Builds the program and expected-store tables from an ISA-level register model,
// drives clock and reset, checks every store event and the load reads, runs a watchdog

`default_nettype none

`include "rv_defs.svh"

module tb_rv_core
    import rv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    dmem_req_t   dmem;
    logic [31:0] dmem_rdata;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] xr [32];        // Architectural register model
    logic [31:0] ram_copy [64];
    int          st_off;         // Next store slot above the base in x31
    int          n_loads;        // LW count of the program
    int          n_reads;        // Cycles with a data read request

    rv_core i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr_o (instr_addr),
        .instr_data_i (instr_data),
        .dmem_o       (dmem),
        .dmem_rdata_i (dmem_rdata)
    );

    tb_rv_mem i_mem (
        .clk          (clk),
        .instr_addr_i (instr_addr),
        .instr_data_o (instr_data),
        .dmem_i       (dmem),
        .dmem_rdata_o (dmem_rdata),
        .st_valid_o   (st_valid),
        .st_addr_o    (st_addr),
        .st_data_o    (st_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // One read request per executed load
    always @(posedge clk) begin
        if (dmem.re === 1'b1) begin
            n_reads++;
        end
    end

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // RV32I integer semantics with alt selecting SUB and SRA
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> sh;
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic set_reg(input int rd, input logic [31:0] v);
        if (rd != 0)
            xr[rd] = v;   // x0 stays zero
    endtask

    task automatic alu_rr(input logic [2:0] f3, input logic alt, input int rd,
                          input int rs1, input int rs2);
        prog.push_back({1'b0, alt, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_ALU});
        set_reg(rd, isa_alu(f3, alt, xr[rs1], xr[rs2]));
    endtask

    task automatic alu_ri(input logic [2:0] f3, input logic [11:0] imm, input int rd,
                          input int rs1);
        prog.push_back({imm, 5'(rs1), f3, 5'(rd), `RV_OP_ALUI});
        set_reg(rd, isa_alu(f3, f3 == 3'd5 && imm[10], xr[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic load_upper(input int rd, input logic [19:0] imm);
        prog.push_back({imm, 5'(rd), `RV_OP_LUI});
        set_reg(rd, {imm, 12'h000});
    endtask

    task automatic load_word(input int rd, input int word);
        prog.push_back({12'(word * 4), 5'd0, 3'b010, 5'(rd), `RV_OP_LOAD});
        set_reg(rd, ram_copy[word]);
        n_loads++;
    endtask

    // Expected only when the store is on the executed path
    task automatic store_reg(input int rs2, input bit live);
        logic [11:0] off;
        off = 12'(st_off);
        prog.push_back({off[11:5], 5'(rs2), 5'd31, 3'b010, off[4:0], `RV_OP_STORE});
        if (live) begin
            exp_addr.push_back(xr[31] + 32'(st_off));
            exp_data.push_back(xr[rs2]);
        end
        st_off += 4;
    endtask

    task automatic branch_over(input bit ne, input int rs1, input int rs2);
        bit taken;
        taken = ne ^ (xr[rs1] == xr[rs2]);
        // Offset +12 lands just past the two stores
        prog.push_back({7'd0, 5'(rs2), 5'(rs1), 2'b00, ne, 4'b0110, 1'b0, `RV_OP_BRANCH});
        store_reg(2, !taken);
        store_reg(3, !taken);
    endtask

    task automatic jump_over(input int rd);
        logic [31:0] link;
        link = 32'(prog.size() * 4 + 4);
        prog.push_back({1'b0, 10'd6, 1'b0, 8'd0, 5'(rd), `RV_OP_JAL});   // JAL +12
        set_reg(rd, link);
        store_reg(2, 1'b0);
        store_reg(3, 1'b0);
        store_reg(rd, 1'b1);
    endtask

    task automatic rr_store(input logic [2:0] f3, input logic alt, input int rs1,
                            input int rs2);
        alu_rr(f3, alt, 10, rs1, rs2);
        store_reg(10, 1'b1);      // Store data forwarded from EX/MEM
    endtask

    task automatic ri_store(input logic [2:0] f3, input logic [11:0] imm);
        alu_ri(f3, imm, 12, 1);
        store_reg(12, 1'b1);
    endtask

    task automatic build_program();
        st_off  = 0;
        n_loads = 0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        alu_ri(3'd0, 12'h020, 31, 0);      // Store base above the load words
        load_upper(1, 20'h87654);
        store_reg(1, 1'b1);
        alu_ri(3'd0, 12'h321, 1, 1);
        load_upper(2, 20'h00012);
        alu_ri(3'd0, 12'hff9, 2, 2);
        alu_ri(3'd0, 12'hffb, 3, 0);       // -5
        alu_ri(3'd0, 12'h003, 4, 0);
        for (int r = 1; r <= 4; r++) begin
            store_reg(r, 1'b1);
        end
        for (int f = 0; f < 8; f++) begin
            for (int a = 0; a < 2; a++) begin
                if (a == 0 || f == 0 || f == 5) begin
                    rr_store(3'(f), a[0], 1, 2);
                    rr_store(3'(f), a[0], 3, 4);
                end
            end
        end
        ri_store(3'd0, 12'h800);
        ri_store(3'd2, 12'hfff);
        ri_store(3'd3, 12'hfff);
        ri_store(3'd4, 12'h5a5);
        ri_store(3'd6, 12'h0f0);
        ri_store(3'd7, 12'h7ff);
        ri_store(3'd1, 12'h007);
        ri_store(3'd5, 12'h007);
        ri_store(3'd5, 12'h407);           // SRAI
        alu_rr(3'd0, 1'b0, 13, 1, 2);
        alu_rr(3'd4, 1'b0, 14, 13, 1);     // x13 from EX/MEM
        alu_rr(3'd0, 1'b1, 15, 13, 14);    // x13 from MEM/WB and x14 from EX/MEM
        store_reg(15, 1'b1);
        load_word(5, 0);
        alu_rr(3'd0, 1'b0, 6, 5, 1);       // Load-use stall
        store_reg(6, 1'b1);
        load_word(7, 3);
        store_reg(7, 1'b1);
        alu_rr(3'd0, 1'b0, 20, 1, 0);
        branch_over(1'b0, 1, 20);          // BEQ taken
        branch_over(1'b1, 1, 20);
        branch_over(1'b1, 1, 2);           // BNE taken
        branch_over(1'b0, 1, 2);
        jump_over(21);
        alu_ri(3'd0, 12'h07b, 0, 0);
        store_reg(0, 1'b1);
        alu_rr(3'd0, 1'b0, 0, 1, 2);
        store_reg(0, 1'b1);
        prog.push_back({20'd0, 5'd0, `RV_OP_JAL});   // Park on a self loop
    endtask

    initial begin
        rst_n = 1'b0;
        @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            ram_copy[i] = i_mem.ram[i];
        end
        build_program();
        foreach (prog[i]) begin
            i_mem.rom[i] = prog[i];
        end
        fork
            begin
                repeat (exp_addr.size() * 40 + 100) @(posedge clk);
                $display("Timeout: the core did not produce all expected stores in time");
                $display("FAIL: see errors above");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < exp_addr.size(); i++) begin
            do begin
                @(negedge clk);
            end while (st_valid !== 1'b1);
            compare_word($sformatf("store %0d address", i), st_addr, exp_addr[i]);
            compare_word($sformatf("store %0d data", i), st_data, exp_data[i]);
        end
        compare_word("data read count", n_reads, n_loads);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_hazard_ctrl.sv
verilog/rv_execute.sv
verilog/rv_memwb.sv
verilog/rv_core.sv
sim/tb_rv_mem.sv
sim/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv32i_pipeline

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_pkg.sv
      - verilog/rv_fetch.sv
      - verilog/rv_decode.sv
      - verilog/rv_regfile.sv
      - verilog/rv_hazard_ctrl.sv
      - verilog/rv_execute.sv
      - verilog/rv_memwb.sv
      - verilog/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_rv_mem.sv
      - sim/tb_rv_core.sv
